//--- design/calc_defines.svh
// Width and pipe depth macros for the execute stage, included by RTL and testbench files
`ifndef CALC_DEFINES_SVH
`define CALC_DEFINES_SVH

// Datapath width
`define CALC_XLEN 32

// Register address width, 32 registers
`define CALC_REG_AW 5

// Dispatched instruction word
`define CALC_INSTR_W 24

// Completion pipe depth, writeback leaves from the last stage
`define CALC_COMP_STAGES 4

// Multiplier latency, also its merge stage in the completion pipe
`define CALC_MUL_STAGES 3

`endif

//--- design/calc_pkg.sv
// Opcodes, instruction word layout and writeback packet shared by the execute stage modules
`default_nettype none

`include "calc_defines.svh"

package calc_pkg;

  typedef enum logic [3:0] {
    e_op_add, e_op_sub, e_op_and, e_op_or, e_op_xor, e_op_sll, e_op_slt,
    e_op_addi, e_op_xori, e_op_mul, e_op_div, e_op_rem
  } op_e;

  // Register view for most opcodes, immediate view for ADDI and XORI
  typedef union packed {
    struct packed {
      logic [4:0]              spare;
      logic [`CALC_REG_AW-1:0] rs2;
      logic [`CALC_REG_AW-1:0] rs1;
      logic [`CALC_REG_AW-1:0] rd;
      op_e                     op;
    } r;
    struct packed {
      logic [9:0]              imm;
      logic [`CALC_REG_AW-1:0] rs1;
      logic [`CALC_REG_AW-1:0] rd;
      op_e                     op;
    } i;
  } instr_u;

  typedef struct packed {
    logic                    w_v;
    logic [`CALC_REG_AW-1:0] rd;
    logic [`CALC_XLEN-1:0]   data;
  } wb_pkt_s;

endpackage

`default_nettype wire

//--- design/calc_rsv_if.sv
// Reservation register contents, driven by the bypass stage and read by every execution pipe
`timescale 1ns/1ps
`default_nettype none

`include "calc_defines.svh"

interface calc_rsv_if;

  logic                    v;
  calc_pkg::op_e           op;
  logic [`CALC_REG_AW-1:0] rd;
  logic                    w_v;
  // Operands after forwarding, src2 carries the immediate for ADDI and XORI
  logic [`CALC_XLEN-1:0]   src1;
  logic [`CALC_XLEN-1:0]   src2;

  modport issue (output v, op, rd, w_v, src1, src2);

  modport exe (input v, op, rd, w_v, src1, src2);

endinterface

`default_nettype wire

//--- design/calc_bypass.sv
// Operand forwarding and reservation register between dispatch and the execution pipes
`timescale 1ns/1ps
`default_nettype none

`include "calc_defines.svh"

module calc_bypass
  (input  logic                                                clk_i
   , input  logic                                              arst_n_i
   , input  logic                                              dispatch_v_i
   , input  calc_pkg::instr_u                                  dispatch_instr_i
   , input  logic [`CALC_XLEN-1:0]                             dispatch_rs1_i
   , input  logic [`CALC_XLEN-1:0]                             dispatch_rs2_i
   , input  logic [`CALC_COMP_STAGES-1:0]                      stage_w_v_i
   , input  logic [`CALC_COMP_STAGES-1:0][`CALC_REG_AW-1:0]    stage_rd_i
   , input  logic [`CALC_COMP_STAGES-1:0][`CALC_XLEN-1:0]      stage_fwd_i
   , calc_rsv_if.issue                                         rsv
   );

  localparam int imm_w = 10;

  calc_pkg::op_e           op;
  logic                    is_imm;
  logic [`CALC_REG_AW-1:0] rs1_addr, rs2_addr, rd_addr;
  logic [`CALC_XLEN-1:0]   imm_ext;
  logic [`CALC_XLEN-1:0]   src1_n, src2_n;

  // Both views share op, rd and rs1 at the same bit positions
  assign op       = dispatch_instr_i.r.op;
  assign is_imm   = (op == calc_pkg::e_op_addi) || (op == calc_pkg::e_op_xori);
  assign rd_addr  = dispatch_instr_i.r.rd;
  assign rs1_addr = dispatch_instr_i.r.rs1;
  assign rs2_addr = dispatch_instr_i.r.rs2;
  assign imm_ext  = {{(`CALC_XLEN-imm_w){dispatch_instr_i.i.imm[imm_w-1]}},
                     dispatch_instr_i.i.imm};

  // Oldest stage first so the youngest match wins
  always_comb
  begin
    src1_n = dispatch_rs1_i;
    src2_n = is_imm ? imm_ext : dispatch_rs2_i;
    for (int s = `CALC_COMP_STAGES-1; s >= 0; s--)
    begin
      if (stage_w_v_i[s] && (stage_rd_i[s] == rs1_addr))
        src1_n = stage_fwd_i[s];
      if (!is_imm && stage_w_v_i[s] && (stage_rd_i[s] == rs2_addr))
        src2_n = stage_fwd_i[s];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rsv.v   <= 1'b0;
      rsv.w_v <= 1'b0;
    end
    else
    begin
      rsv.v   <= dispatch_v_i;
      rsv.w_v <= dispatch_v_i && (op != calc_pkg::e_op_div) && (op != calc_pkg::e_op_rem);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (dispatch_v_i)
    begin
      rsv.op   <= op;
      rsv.rd   <= rd_addr;
      rsv.src1 <= src1_n;
      rsv.src2 <= src2_n;
    end
  end

endmodule

`default_nettype wire

//--- design/calc_pipe_int.sv
// Single-cycle ALU working on the reservation register, result merges into completion stage 1
`timescale 1ns/1ps
`default_nettype none

`include "calc_defines.svh"

module calc_pipe_int
  (calc_rsv_if.exe                   rsv
   , output logic                    int_v_o
   , output logic [`CALC_XLEN-1:0]   int_data_o
   );

  logic is_alu;
  logic lt;

  assign lt = $signed(rsv.src1) < $signed(rsv.src2);

  always_comb
  begin
    is_alu     = 1'b1;
    int_data_o = '0;
    case (rsv.op)
      calc_pkg::e_op_add, calc_pkg::e_op_addi: int_data_o = rsv.src1 + rsv.src2;
      calc_pkg::e_op_sub:                      int_data_o = rsv.src1 - rsv.src2;
      calc_pkg::e_op_and:                      int_data_o = rsv.src1 & rsv.src2;
      calc_pkg::e_op_or:                       int_data_o = rsv.src1 | rsv.src2;
      calc_pkg::e_op_xor, calc_pkg::e_op_xori: int_data_o = rsv.src1 ^ rsv.src2;
      // Shift amount from the low 5 bits only
      calc_pkg::e_op_sll:                      int_data_o = rsv.src1 << rsv.src2[4:0];
      calc_pkg::e_op_slt:                      int_data_o = {{(`CALC_XLEN-1){1'b0}}, lt};
      default:                                 is_alu = 1'b0;
    endcase
  end

  assign int_v_o = rsv.v && is_alu;

endmodule

`default_nettype wire

//--- design/calc_pipe_mul.sv
// Pipelined multiplier returning the low product word, one new operation accepted every cycle
`timescale 1ns/1ps
`default_nettype none

`include "calc_defines.svh"

module calc_pipe_mul
  (input  logic                      clk_i
   , input  logic                    arst_n_i
   , calc_rsv_if.exe                 rsv
   , output logic                    mul_v_o
   , output logic [`CALC_XLEN-1:0]   mul_data_o
   );

  localparam int half_w = `CALC_XLEN / 2;

  logic                  v1_r, v2_r;
  // First stage keeps only the partial products that reach the low word
  logic [`CALC_XLEN-1:0] p_ll_r;
  logic [half_w-1:0]     p_cross_r;
  logic [`CALC_XLEN-1:0] prod_r;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      v1_r <= 1'b0;
      v2_r <= 1'b0;
    end
    else
    begin
      v1_r <= rsv.v && (rsv.op == calc_pkg::e_op_mul);
      v2_r <= v1_r;
    end
  end

  always_ff @(posedge clk_i)
  begin
    p_ll_r    <= rsv.src1[half_w-1:0] * rsv.src2[half_w-1:0];
    p_cross_r <= half_w'(rsv.src1[half_w-1:0] * rsv.src2[`CALC_XLEN-1:half_w])
               + half_w'(rsv.src1[`CALC_XLEN-1:half_w] * rsv.src2[half_w-1:0]);
    prod_r    <= p_ll_r + {p_cross_r, {half_w{1'b0}}};
  end

  assign mul_v_o    = v2_r;
  assign mul_data_o = prod_r;

endmodule

`default_nettype wire

//--- design/calc_pipe_div.sv
// Iterative unsigned divider for DIV and REM, result leaves on the late writeback handshake
`timescale 1ns/1ps
`default_nettype none

`include "calc_defines.svh"

module calc_pipe_div
  (input  logic                 clk_i
   , input  logic               arst_n_i
   , calc_rsv_if.exe            rsv
   , output logic               busy_o
   , output calc_pkg::wb_pkt_s  late_wb_o
   , output logic               late_wb_v_o
   , input  logic               late_wb_yumi_i
   );

  localparam int cnt_w = $clog2(`CALC_XLEN + 1);

  logic                    is_div_op, start, running;
  logic                    busy_r, done_r, is_rem_r;
  logic [cnt_w-1:0]        cnt_r;
  logic [`CALC_REG_AW-1:0] rd_r;
  logic [`CALC_XLEN-1:0]   quot_r, rem_r, divisor_r;
  logic [`CALC_XLEN:0]     shifted, diff;

  assign is_div_op = (rsv.op == calc_pkg::e_op_div) || (rsv.op == calc_pkg::e_op_rem);
  assign start     = rsv.v && is_div_op && !busy_r;
  assign running   = busy_r && !done_r;

  // Restoring step, a zero divisor falls out as all ones and the dividend
  assign shifted = {rem_r, quot_r[`CALC_XLEN-1]};
  assign diff    = shifted - {1'b0, divisor_r};

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      busy_r <= 1'b0;
      done_r <= 1'b0;
      cnt_r  <= '0;
    end
    else if (start)
    begin
      busy_r <= 1'b1;
      cnt_r  <= cnt_w'(`CALC_XLEN);
    end
    else if (running)
    begin
      cnt_r <= cnt_r - 1'b1;
      if (cnt_r == cnt_w'(1))
        done_r <= 1'b1;
    end
    else if (done_r && late_wb_yumi_i)
    begin
      busy_r <= 1'b0;
      done_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (start)
    begin
      quot_r    <= rsv.src1;
      rem_r     <= '0;
      divisor_r <= rsv.src2;
      rd_r      <= rsv.rd;
      is_rem_r  <= (rsv.op == calc_pkg::e_op_rem);
    end
    else if (running)
    begin
      quot_r <= {quot_r[`CALC_XLEN-2:0], ~diff[`CALC_XLEN]};
      rem_r  <= diff[`CALC_XLEN] ? shifted[`CALC_XLEN-1:0] : diff[`CALC_XLEN-1:0];
    end
  end

  // Busy from the cycle the reservation holds the divide
  assign busy_o         = busy_r || (rsv.v && is_div_op);
  assign late_wb_v_o    = done_r;
  assign late_wb_o.w_v  = done_r;
  assign late_wb_o.rd   = rd_r;
  assign late_wb_o.data = is_rem_r ? rem_r : quot_r;

endmodule

`default_nettype wire

//--- design/calc_comp_pipe.sv
// Completion pipe that merges fixed-latency results and presents the integer writeback
`timescale 1ns/1ps
`default_nettype none

`include "calc_defines.svh"

module calc_comp_pipe
  (input  logic                                                clk_i
   , input  logic                                              arst_n_i
   , calc_rsv_if.exe                                           rsv
   , input  logic                                              int_v_i
   , input  logic [`CALC_XLEN-1:0]                             int_data_i
   , input  logic                                              mul_v_i
   , input  logic [`CALC_XLEN-1:0]                             mul_data_i
   , output logic [`CALC_COMP_STAGES-1:0]                      stage_w_v_o
   , output logic [`CALC_COMP_STAGES-1:0][`CALC_REG_AW-1:0]    stage_rd_o
   , output logic [`CALC_COMP_STAGES-1:0][`CALC_XLEN-1:0]      stage_fwd_o
   , output calc_pkg::wb_pkt_s                                 iwb_o
   );

  localparam int stages    = `CALC_COMP_STAGES;
  localparam int int_stage = 1;
  localparam int mul_stage = `CALC_MUL_STAGES;

  // Stage 0 is the reservation register itself
  calc_pkg::wb_pkt_s [stages-1:0] stage_cur;
  calc_pkg::wb_pkt_s [stages:1]   stage_n;

  logic [stages-1:1]                        w_v_r;
  logic [stages-1:1][`CALC_REG_AW-1:0]      rd_r;
  logic [stages-1:1][`CALC_XLEN-1:0]        data_r;

  always_comb
  begin
    stage_cur[0] = '{w_v: rsv.w_v, rd: rsv.rd, data: '0};
    for (int i = 1; i < stages; i++)
      stage_cur[i] = '{w_v: w_v_r[i], rd: rd_r[i], data: data_r[i]};
    for (int i = 1; i <= stages; i++)
      stage_n[i] = stage_cur[i-1];
    // Static latencies keep the two merges apart
    stage_n[int_stage].data |= int_v_i ? int_data_i : '0;
    stage_n[mul_stage].data |= mul_v_i ? mul_data_i : '0;
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      w_v_r <= '0;
    else
      for (int i = 1; i < stages; i++)
        w_v_r[i] <= stage_n[i].w_v;
  end

  always_ff @(posedge clk_i)
  begin
    for (int i = 1; i < stages; i++)
    begin
      rd_r[i]   <= stage_n[i].rd;
      data_r[i] <= stage_n[i].data;
    end
  end

  for (genvar s = 0; s < stages; s++)
  begin : g_fwd
    assign stage_w_v_o[s] = stage_cur[s].w_v;
    assign stage_rd_o[s]  = stage_cur[s].rd;
    assign stage_fwd_o[s] = stage_n[s+1].data;
  end

  assign iwb_o = stage_cur[stages-1];

endmodule

`default_nettype wire

//--- design/calc_top.sv
// Execute stage top level with plain ports, connects bypass, pipes and completion pipe
`timescale 1ns/1ps
`default_nettype none

`include "calc_defines.svh"

module calc_top
  (input  logic                        clk_i
   , input  logic                      arst_n_i
   , input  logic                      dispatch_v_i
   , input  logic [`CALC_INSTR_W-1:0]  dispatch_instr_i
   , input  logic [`CALC_XLEN-1:0]     dispatch_rs1_i
   , input  logic [`CALC_XLEN-1:0]     dispatch_rs2_i
   , output logic                      div_busy_o
   , output logic                      iwb_v_o
   , output logic [`CALC_REG_AW-1:0]   iwb_rd_o
   , output logic [`CALC_XLEN-1:0]     iwb_data_o
   , output logic                      late_wb_v_o
   , output logic [`CALC_REG_AW-1:0]   late_wb_rd_o
   , output logic [`CALC_XLEN-1:0]     late_wb_data_o
   , input  logic                      late_wb_yumi_i
   );

  calc_pkg::instr_u                               dispatch_instr;
  logic [`CALC_COMP_STAGES-1:0]                   stage_w_v;
  logic [`CALC_COMP_STAGES-1:0][`CALC_REG_AW-1:0] stage_rd;
  logic [`CALC_COMP_STAGES-1:0][`CALC_XLEN-1:0]   stage_fwd;
  logic                                           int_v, mul_v;
  logic [`CALC_XLEN-1:0]                          int_data, mul_data;
  calc_pkg::wb_pkt_s                              iwb_pkt, late_wb_pkt;

  calc_rsv_if rsv_if ();

  assign dispatch_instr = dispatch_instr_i;

  calc_bypass calc_bypass_inst
    (.clk_i(clk_i), .arst_n_i(arst_n_i), .dispatch_v_i(dispatch_v_i)
     , .dispatch_instr_i(dispatch_instr), .dispatch_rs1_i(dispatch_rs1_i)
     , .dispatch_rs2_i(dispatch_rs2_i), .stage_w_v_i(stage_w_v), .stage_rd_i(stage_rd)
     , .stage_fwd_i(stage_fwd), .rsv(rsv_if.issue));

  calc_pipe_int calc_pipe_int_inst
    (.rsv(rsv_if.exe), .int_v_o(int_v), .int_data_o(int_data));

  calc_pipe_mul calc_pipe_mul_inst
    (.clk_i(clk_i), .arst_n_i(arst_n_i), .rsv(rsv_if.exe)
     , .mul_v_o(mul_v), .mul_data_o(mul_data));

  calc_pipe_div calc_pipe_div_inst
    (.clk_i(clk_i), .arst_n_i(arst_n_i), .rsv(rsv_if.exe), .busy_o(div_busy_o)
     , .late_wb_o(late_wb_pkt), .late_wb_v_o(late_wb_v_o), .late_wb_yumi_i(late_wb_yumi_i));

  calc_comp_pipe calc_comp_pipe_inst
    (.clk_i(clk_i), .arst_n_i(arst_n_i), .rsv(rsv_if.exe)
     , .int_v_i(int_v), .int_data_i(int_data), .mul_v_i(mul_v), .mul_data_i(mul_data)
     , .stage_w_v_o(stage_w_v), .stage_rd_o(stage_rd), .stage_fwd_o(stage_fwd)
     , .iwb_o(iwb_pkt));

  assign iwb_v_o        = iwb_pkt.w_v;
  assign iwb_rd_o       = iwb_pkt.rd;
  assign iwb_data_o     = iwb_pkt.data;
  assign late_wb_rd_o   = late_wb_pkt.rd;
  assign late_wb_data_o = late_wb_pkt.data;

endmodule

`default_nettype wire

//--- sim/calc_chk.sv
// Concurrent assertions on reset and late writeback behavior, bound to the execute stage top
`timescale 1ns/1ps
`default_nettype none

`include "calc_defines.svh"

module calc_chk
  (input  logic                      clk_i
   , input  logic                    arst_n_i
   , input  logic                    div_busy_i
   , input  logic                    iwb_v_i
   , input  logic                    late_wb_v_i
   , input  logic [`CALC_REG_AW-1:0] late_wb_rd_i
   , input  logic [`CALC_XLEN-1:0]   late_wb_data_i
   , input  logic                    late_wb_yumi_i
   );

  int unsigned fail_cnt = 0;

  // Packet and valid hold while yumi is withheld
  late_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      late_wb_v_i && !late_wb_yumi_i |=>
        late_wb_v_i && $stable(late_wb_rd_i) && $stable(late_wb_data_i))
    else
    begin
      fail_cnt++;
      $error("late writeback changed or dropped while yumi was low");
    end

  // Quiet in reset and in the first cycle after it
  reset_quiet_a: assert property (@(posedge clk_i)
      (!arst_n_i || $rose(arst_n_i)) |-> !iwb_v_i && !late_wb_v_i && !div_busy_i)
    else
    begin
      fail_cnt++;
      $error("valid or busy output high during or right after reset");
    end

  late_busy_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      late_wb_v_i |-> div_busy_i)
    else
    begin
      fail_cnt++;
      $error("late writeback valid while the divider is not busy");
    end

endmodule

`default_nettype wire

//--- sim/calc_monitor.sv
// Program-order model of the execute stage, compares both writeback ports of the DUT
`timescale 1ns/1ps
`default_nettype none

`include "calc_defines.svh"

module calc_monitor
  (input  logic                        clk_i
   , input  logic                      arst_n_i
   , input  logic                      dispatch_v_i
   , input  logic [`CALC_INSTR_W-1:0]  dispatch_instr_i
   , input  logic                      div_busy_i
   , input  logic                      iwb_v_i
   , input  logic [`CALC_REG_AW-1:0]   iwb_rd_i
   , input  logic [`CALC_XLEN-1:0]     iwb_data_i
   , input  logic                      late_wb_v_i
   , input  logic [`CALC_REG_AW-1:0]   late_wb_rd_i
   , input  logic [`CALC_XLEN-1:0]     late_wb_data_i
   , input  logic                      late_wb_yumi_i
   , output int                        value_err_o
   , output int                        proto_err_o
   , output int                        iwb_cnt_o
   , output int                        late_cnt_o
   , output int                        pending_o
   );

  localparam int wb_delay = 3;

  typedef struct packed {
    logic [`CALC_REG_AW-1:0] rd;
    logic [`CALC_XLEN-1:0]   data;
    logic [31:0]             due;
  } exp_wb_s;

  logic [`CALC_XLEN-1:0] arch_rf [2**`CALC_REG_AW];
  exp_wb_s               iwb_q [$];
  exp_wb_s               late_q [$];
  logic [31:0]           cycle;
  logic                  late_v_seen, late_taken;

  // Executes one instruction against the architectural state in program order
  task automatic accept(input logic [`CALC_INSTR_W-1:0] instr);
    logic [3:0]              op;
    logic [`CALC_REG_AW-1:0] rd;
    logic [`CALC_XLEN-1:0]   a, b, res;
    exp_wb_s                 e;
    op = instr[3:0];
    rd = instr[8:4];
    a  = arch_rf[instr[13:9]];
    if (op == calc_pkg::e_op_addi || op == calc_pkg::e_op_xori)
      b = {{(`CALC_XLEN-10){instr[23]}}, instr[23:14]};
    else
      b = arch_rf[instr[18:14]];
    case (op)
      calc_pkg::e_op_add, calc_pkg::e_op_addi: res = a + b;
      calc_pkg::e_op_sub:                      res = a - b;
      calc_pkg::e_op_and:                      res = a & b;
      calc_pkg::e_op_or:                       res = a | b;
      calc_pkg::e_op_xor, calc_pkg::e_op_xori: res = a ^ b;
      calc_pkg::e_op_sll:                      res = a << b[4:0];
      calc_pkg::e_op_slt:                      res = ($signed(a) < $signed(b)) ? 1 : 0;
      calc_pkg::e_op_mul:                      res = a * b;
      calc_pkg::e_op_div:                      res = (b == 0) ? '1 : a / b;
      calc_pkg::e_op_rem:                      res = (b == 0) ? a : a % b;
      default:                                 res = '0;
    endcase
    arch_rf[rd] = res;
    e = '{rd: rd, data: res, due: cycle + wb_delay};
    if (op == calc_pkg::e_op_div || op == calc_pkg::e_op_rem)
      late_q.push_back(e);
    else
      iwb_q.push_back(e);
  endtask

  always @(posedge clk_i)
  begin
    if (!arst_n_i)
    begin
      iwb_q.delete();
      late_q.delete();
      for (int r = 0; r < 2**`CALC_REG_AW; r++)
        arch_rf[r] = '0;
      cycle      = 0;
      late_cnt_o = 0;
      pending_o  = 0;
      late_taken = 1'b0;
    end
    else
    begin
      cycle      = cycle + 1;
      late_taken = late_v_seen && late_wb_yumi_i;
      if (late_taken && late_q.size() > 0)
      begin
        late_q.delete(0);
        late_cnt_o = late_cnt_o + 1;
      end
      if (dispatch_v_i)
        accept(dispatch_instr_i);
      pending_o = iwb_q.size() + late_q.size();
    end
  end

  always @(negedge clk_i)
  begin : check_outputs
    exp_wb_s e;
    if (!arst_n_i)
    begin
      value_err_o = 0;
      proto_err_o = 0;
      iwb_cnt_o   = 0;
      late_v_seen = 1'b0;
    end
    else
    begin
      if (late_taken && div_busy_i)
      begin
        proto_err_o++;
        $display("ERROR at %0t: div_busy_o still high after the late writeback was taken",
                 $time);
      end
      if (iwb_v_i)
      begin
        if (iwb_q.size() == 0)
        begin
          proto_err_o++;
          $display("ERROR at %0t: integer writeback with no ALU or MUL result due", $time);
        end
        else
        begin
          e = iwb_q.pop_front();
          iwb_cnt_o++;
          if (e.due != cycle)
          begin
            proto_err_o++;
            $display("ERROR at %0t: writeback for rd %0d came at cycle %0d instead of %0d",
                     $time, e.rd, cycle, e.due);
          end
          if (iwb_rd_i !== e.rd)
          begin
            value_err_o++;
            $display("CHECK FAILED at %0t: iwb_rd_o expected %0d, got %0d",
                     $time, e.rd, iwb_rd_i);
          end
          if (iwb_data_i !== e.data)
          begin
            value_err_o++;
            $display("CHECK FAILED at %0t: iwb_data_o expected %h, got %h",
                     $time, e.data, iwb_data_i);
          end
        end
      end
      else if (iwb_q.size() > 0 && iwb_q[0].due <= cycle)
      begin
        e = iwb_q.pop_front();
        proto_err_o++;
        $display("ERROR at %0t: missing integer writeback for rd %0d", $time, e.rd);
      end
      late_v_seen = late_wb_v_i;
      if (late_wb_v_i)
      begin
        if (late_q.size() == 0)
        begin
          proto_err_o++;
          $display("ERROR at %0t: late writeback with no divide outstanding", $time);
        end
        else
        begin
          if (late_wb_rd_i !== late_q[0].rd)
          begin
            value_err_o++;
            $display("CHECK FAILED at %0t: late_wb_rd_o expected %0d, got %0d",
                     $time, late_q[0].rd, late_wb_rd_i);
          end
          if (late_wb_data_i !== late_q[0].data)
          begin
            value_err_o++;
            $display("CHECK FAILED at %0t: late_wb_data_o expected %h, got %h",
                     $time, late_q[0].data, late_wb_data_i);
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/calc_tb.sv
// Simulation top that drives a random instruction stream with stale operands into the execute stage
`timescale 1ns/1ps
`default_nettype none

`include "calc_defines.svh"

module calc_tb;

  localparam int num_instr   = 400;
  localparam int stall_limit = 400;
  localparam int drain_limit = 600;
  localparam int mul_gap     = 3;

  logic                      clk, arst_n;
  logic                      dispatch_v;
  logic [`CALC_INSTR_W-1:0]  dispatch_instr;
  logic [`CALC_XLEN-1:0]     dispatch_rs1, dispatch_rs2;
  logic                      div_busy, iwb_v, late_wb_v, late_wb_yumi;
  logic [`CALC_REG_AW-1:0]   iwb_rd, late_wb_rd;
  logic [`CALC_XLEN-1:0]     iwb_data, late_wb_data;
  int                        value_err, proto_err, iwb_cnt, late_cnt, pending;

  // Register file outside the DUT that only the writeback ports update
  logic [`CALC_XLEN-1:0]     stale_rf [2**`CALC_REG_AW];
  int                        last_mul [2**`CALC_REG_AW];
  logic [`CALC_REG_AW-1:0]   reg_pool [8] = '{5'd0, 5'd3, 5'd4, 5'd7, 5'd12, 5'd19, 5'd28, 5'd31};
  int                        tb_cycle;
  logic                      timed_out;
  logic                      late_take;
  logic [`CALC_REG_AW-1:0]   take_rd;
  logic [`CALC_XLEN-1:0]     take_data;

  calc_top calc_top_inst
    (.clk_i(clk), .arst_n_i(arst_n), .dispatch_v_i(dispatch_v)
     , .dispatch_instr_i(dispatch_instr), .dispatch_rs1_i(dispatch_rs1)
     , .dispatch_rs2_i(dispatch_rs2), .div_busy_o(div_busy), .iwb_v_o(iwb_v)
     , .iwb_rd_o(iwb_rd), .iwb_data_o(iwb_data), .late_wb_v_o(late_wb_v)
     , .late_wb_rd_o(late_wb_rd), .late_wb_data_o(late_wb_data)
     , .late_wb_yumi_i(late_wb_yumi));

  calc_monitor calc_monitor_inst
    (.clk_i(clk), .arst_n_i(arst_n), .dispatch_v_i(dispatch_v)
     , .dispatch_instr_i(dispatch_instr), .div_busy_i(div_busy), .iwb_v_i(iwb_v)
     , .iwb_rd_i(iwb_rd), .iwb_data_i(iwb_data), .late_wb_v_i(late_wb_v)
     , .late_wb_rd_i(late_wb_rd), .late_wb_data_i(late_wb_data)
     , .late_wb_yumi_i(late_wb_yumi), .value_err_o(value_err), .proto_err_o(proto_err)
     , .iwb_cnt_o(iwb_cnt), .late_cnt_o(late_cnt), .pending_o(pending));

  bind calc_top calc_chk calc_chk_inst
    (.clk_i(clk_i), .arst_n_i(arst_n_i), .div_busy_i(div_busy_o), .iwb_v_i(iwb_v_o)
     , .late_wb_v_i(late_wb_v_o), .late_wb_rd_i(late_wb_rd_o)
     , .late_wb_data_i(late_wb_data_o), .late_wb_yumi_i(late_wb_yumi_i));

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Absorbs writebacks, clears dispatch and picks a new yumi on each falling edge
  task automatic advance_cycle;
    @(negedge clk);
    tb_cycle++;
    if (late_take)
      stale_rf[take_rd] = take_data;
    if (iwb_v)
      stale_rf[iwb_rd] = iwb_data;
    dispatch_v   = 1'b0;
    late_wb_yumi = ($urandom_range(0, 3) != 0);
    late_take    = late_wb_v && late_wb_yumi;
    take_rd      = late_wb_rd;
    take_data    = late_wb_data;
  endtask

  task automatic wait_ready(input logic [`CALC_REG_AW-1:0] rs1,
                            input logic [`CALC_REG_AW-1:0] rs2, input logic use_rs2);
    int guard;
    guard = 0;
    while (!timed_out && (div_busy || (tb_cycle - last_mul[rs1] < mul_gap)
           || (use_rs2 && (tb_cycle - last_mul[rs2] < mul_gap))))
    begin
      advance_cycle();
      guard++;
      if (guard > stall_limit)
      begin
        $display("TIMEOUT at %0t: divider stayed busy for %0d cycles", $time, guard);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic issue_random;
    int                       pick;
    calc_pkg::op_e            op;
    logic [`CALC_REG_AW-1:0]  rd, rs1, rs2;
    logic [9:0]               imm;
    logic                     is_imm;
    logic [`CALC_INSTR_W-1:0] word;
    pick = $urandom_range(0, 99);
    if (pick < 55)
      op = calc_pkg::op_e'($urandom_range(0, 6));
    else if (pick < 75)
      op = (pick < 65) ? calc_pkg::e_op_addi : calc_pkg::e_op_xori;
    else if (pick < 90)
      op = calc_pkg::e_op_mul;
    else
      op = (pick < 95) ? calc_pkg::e_op_div : calc_pkg::e_op_rem;
    rd  = reg_pool[$urandom_range(0, 7)];
    rs1 = reg_pool[$urandom_range(0, 7)];
    rs2 = reg_pool[$urandom_range(0, 7)];
    // A SUB of a register from itself clears rd and makes zero divisors likely
    if (op == calc_pkg::e_op_sub && $urandom_range(0, 3) == 0)
      rs2 = rs1;
    is_imm = (op == calc_pkg::e_op_addi) || (op == calc_pkg::e_op_xori);
    imm    = 10'($urandom);
    // Immediate bits often alias a live register in the rs2 field
    if ($urandom_range(0, 1) == 0)
      imm[4:0] = rs2;
    if (is_imm)
      word = {imm, rs1, rd, op};
    else
      word = {5'($urandom), rs2, rs1, rd, op};
    wait_ready(rs1, word[18:14], !is_imm);
    if (!timed_out)
    begin
      dispatch_v     = 1'b1;
      dispatch_instr = word;
      dispatch_rs1   = stale_rf[rs1];
      dispatch_rs2   = stale_rf[word[18:14]];
      if (op == calc_pkg::e_op_mul)
        last_mul[rd] = tb_cycle;
      advance_cycle();
    end
  endtask

  task automatic drain;
    int guard;
    guard = 0;
    while (!timed_out && (pending != 0 || div_busy))
    begin
      advance_cycle();
      guard++;
      if (guard > drain_limit)
      begin
        $display("TIMEOUT at %0t: %0d writebacks still outstanding after %0d cycles",
                 $time, pending, guard);
        timed_out = 1'b1;
      end
    end
  endtask

  initial
  begin
    int total;
    void'($urandom(32'he146));
    arst_n         = 1'b0;
    dispatch_v     = 1'b0;
    dispatch_instr = '0;
    dispatch_rs1   = '0;
    dispatch_rs2   = '0;
    late_wb_yumi   = 1'b0;
    late_take      = 1'b0;
    take_rd        = '0;
    take_data      = '0;
    tb_cycle       = 0;
    timed_out      = 1'b0;
    for (int r = 0; r < 2**`CALC_REG_AW; r++)
    begin
      stale_rf[r] = '0;
      last_mul[r] = -100;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    advance_cycle();
    for (int n = 0; n < num_instr && !timed_out; n++)
    begin
      if ($urandom_range(0, 4) == 0)
        repeat ($urandom_range(1, 3)) advance_cycle();
      issue_random();
    end
    if (!timed_out)
    begin
      drain();
      // Quiet cycles to catch a stray or duplicated writeback
      repeat (4) advance_cycle();
    end
    total = value_err + proto_err + int'(calc_top_inst.calc_chk_inst.fail_cnt)
          + (timed_out ? 1 : 0);
    $display("Errors: %0d value, %0d protocol, %0d assertion, %0d timeout; %0d iwb, %0d late",
             value_err, proto_err, calc_top_inst.calc_chk_inst.fail_cnt, timed_out ? 1 : 0,
             iwb_cnt, late_cnt);
    if (total == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+design
design/calc_pkg.sv
design/calc_rsv_if.sv
design/calc_bypass.sv
design/calc_pipe_int.sv
design/calc_pipe_mul.sv
design/calc_pipe_div.sv
design/calc_comp_pipe.sv
design/calc_top.sv
sim/calc_chk.sv
sim/calc_monitor.sv
sim/calc_tb.sv
